// File: common/issue_pkg.sv
package issue_pkg;

    typedef logic [4:0] reg_addr_t;     // architectural register index
    typedef logic [1:0] unit_t;         // functional unit code
    typedef logic [4:0] row_t;          // one-hot countdown, bit 0 = result on bypass
    typedef logic [1:0] fwd_sel_t;      // operand source at execute

    // unit codes, 3 behaves as mult
    localparam unit_t unit_alu  = 2'd0;
    localparam unit_t unit_mem  = 2'd1;
    localparam unit_t unit_mult = 2'd2;

    // operand sources
    localparam fwd_sel_t fwd_none = 2'd0;   // register file
    localparam fwd_sel_t fwd_alu  = 2'd1;
    localparam fwd_sel_t fwd_mem  = 2'd2;
    localparam fwd_sel_t fwd_mult = 2'd3;

    // start rows per unit, and the last step before retire
    localparam row_t row_alu  = 5'b00010;
    localparam row_t row_mem  = 5'b00100;
    localparam row_t row_mult = 5'b10000;
    localparam row_t row_last = 5'b00001;

    typedef struct packed {
        logic  pending;     // result still in flight
        unit_t unit;        // producer
        row_t  row;
    } sb_entry_t;

    typedef struct packed {
        reg_addr_t src_a;
        reg_addr_t src_b;
        reg_addr_t dst;
        unit_t     unit;
        logic      writes_dst;
    } issue_instr_t;

    typedef struct packed {
        issue_instr_t instr;
        fwd_sel_t     fwd_a;
        fwd_sel_t     fwd_b;
    } exec_op_t;

    // row a fresh write starts with
    function automatic row_t unit_row(input unit_t unit);
        case (unit)
            unit_alu: unit_row = row_alu;
            unit_mem: unit_row = row_mem;
            default:  unit_row = row_mult;   // mult and code 3
        endcase
    endfunction

endpackage

// File: common/sb_read_if.sv
interface sb_read_if import issue_pkg::*; ();

    reg_addr_t addr;        // register being looked up
    logic      pending;
    unit_t     unit;
    row_t      row;

    // scoreboard answers the lookup
    modport scoreboard (
        input  addr,
        output pending,
        output unit,
        output row
    );

    // issue side asks and checks
    modport requester (
        output addr,
        input  pending,
        input  unit,
        input  row
    );

endinterface

// File: scoreboard/scoreboard.sv
module scoreboard import issue_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    sb_read_if.scoreboard rd_a,
    sb_read_if.scoreboard rd_b,
    input  logic          we,       // issue claims waddr
    input  reg_addr_t     waddr,
    input  unit_t         wunit
);

    sb_entry_t [31:0] entries;
    sb_entry_t [31:0] entries_next;

    // both lookups are plain reads of the current table
    assign rd_a.pending = entries[rd_a.addr].pending;
    assign rd_a.unit    = entries[rd_a.addr].unit;
    assign rd_a.row     = entries[rd_a.addr].row;

    assign rd_b.pending = entries[rd_b.addr].pending;
    assign rd_b.unit    = entries[rd_b.addr].unit;
    assign rd_b.row     = entries[rd_b.addr].row;

    always_comb begin
        for (int i = 0; i < 32; i++) begin
            entries_next[i].row = entries[i].row >> 1;     // one step closer
            if (entries_next[i].row == '0) begin
                // retired, entry becomes free
                entries_next[i].pending = 1'b0;
                entries_next[i].unit    = unit_alu;
            end else begin
                entries_next[i].pending = entries[i].pending;
                entries_next[i].unit    = entries[i].unit;
            end
        end

        // issue write lands on top of the shifted row
        if (we) begin
            entries_next[waddr].pending = 1'b1;
            entries_next[waddr].unit    = wunit;
            entries_next[waddr].row     = entries_next[waddr].row | unit_row(wunit);
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            entries <= '0;      // everything free
        end else begin
            entries <= entries_next;
        end
    end

endmodule

// File: verilog/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     load,      // take in_valid and in_data
    input  logic     bubble,    // drop the held op
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     valid,
    output payload_t data
);

    // occupancy, load wins over bubble
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= in_valid;
        end else if (bubble) begin
            valid <= 1'b0;
        end
    end

    // payload only moves on load
    always_ff @(posedge clock) begin
        if (load) begin
            data <= in_data;
        end
    end

endmodule

// File: verilog/operand_bypass.sv
module operand_bypass import issue_pkg::*; (
    sb_read_if.requester rd,
    output logic         ready,     // operand can be used this cycle
    output fwd_sel_t     fwd
);

    logic on_bypass;    // producer result sits on its bypass now

    assign on_bypass = rd.pending && (rd.row == row_last);

    // free in the register file, or caught off the bypass
    assign ready = !rd.pending || on_bypass;

    always_comb begin
        fwd = fwd_none;
        if (on_bypass) begin
            case (rd.unit)
                unit_alu: fwd = fwd_alu;
                unit_mem: fwd = fwd_mem;
                default:  fwd = fwd_mult;   // code 3 too
            endcase
        end
    end

endmodule

// File: verilog/issue_control.sv
module issue_control import issue_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                dec_valid,
    input  issue_instr_t        dec_instr,
    sb_read_if.requester        rd_a,
    sb_read_if.requester        rd_b,
    input  logic                ready_a,
    input  logic                ready_b,
    input  fwd_sel_t            fwd_a,
    input  fwd_sel_t            fwd_b,
    input  logic                in_valid,
    output logic                in_ready,
    output logic                load_dec,
    output logic                exec_load,
    output logic                exec_bubble,
    output exec_op_t            exec_op,
    output logic                sb_we,
    output reg_addr_t           sb_waddr,
    output unit_t               sb_wunit
);

    // rows written over the last four edges, slot k is k edges old
    reg_addr_t wr_dst_q [4];
    row_t      wr_row_q [4];

    logic dec_writes;   // decode op claims a register
    logic waw_hit;      // its dst is still owned by an older result
    logic issue;

    assign rd_a.addr = dec_instr.src_a;
    assign rd_b.addr = dec_instr.src_b;

    assign dec_writes = dec_instr.writes_dst && (dec_instr.dst != '0);   // r0 never tracked

    // dst busy while its row is above bit 0
    always_comb begin
        waw_hit = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if (wr_dst_q[k] == dec_instr.dst && wr_row_q[k][4:1] != '0) begin
                waw_hit = 1'b1;
            end
        end
    end

    assign issue = dec_valid && ready_a && ready_b && !(dec_writes && waw_hit);

    assign in_ready    = !dec_valid || issue;
    assign load_dec    = in_valid ? in_ready : issue;   // empty the latch when nothing comes
    assign exec_load   = issue;
    assign exec_bubble = !issue;                        // stall cycle goes out as a bubble

    assign exec_op = '{instr: dec_instr, fwd_a: fwd_a, fwd_b: fwd_b};

    assign sb_we    = issue && dec_writes;
    assign sb_waddr = dec_instr.dst;
    assign sb_wunit = dec_instr.unit;

    // shadow of the recent writes, rows shift like the scoreboard
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int k = 0; k < 4; k++) begin
                wr_dst_q[k] <= '0;
                wr_row_q[k] <= '0;
            end
        end else begin
            wr_dst_q[0] <= sb_waddr;
            wr_row_q[0] <= sb_we ? unit_row(sb_wunit) : '0;
            for (int k = 1; k < 4; k++) begin
                wr_dst_q[k] <= wr_dst_q[k-1];
                wr_row_q[k] <= wr_row_q[k-1] >> 1;
            end
        end
    end

endmodule

// File: verilog/issue_stage_top.sv
module issue_stage_top import issue_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      in_valid,
    input  reg_addr_t in_src_a,
    input  reg_addr_t in_src_b,
    input  reg_addr_t in_dst,
    input  unit_t     in_unit,
    input  logic      in_writes_dst,
    output logic      in_ready,
    output logic      out_valid,
    output reg_addr_t out_src_a,
    output reg_addr_t out_src_b,
    output reg_addr_t out_dst,
    output unit_t     out_unit,
    output logic      out_writes_dst,
    output fwd_sel_t  out_fwd_a,
    output fwd_sel_t  out_fwd_b
);

    sb_read_if rd_a ();     // source a lookup
    sb_read_if rd_b ();     // source b lookup

    issue_instr_t in_instr;
    issue_instr_t dec_instr;
    exec_op_t     exec_op;
    exec_op_t     exec_q;
    logic         dec_valid;
    logic         load_dec;
    logic         exec_load;
    logic         exec_bubble;
    logic         ready_a;
    logic         ready_b;
    fwd_sel_t     fwd_a;
    fwd_sel_t     fwd_b;
    logic         sb_we;
    reg_addr_t    sb_waddr;
    unit_t        sb_wunit;

    assign in_instr = '{src_a: in_src_a, src_b: in_src_b, dst: in_dst,
                        unit: in_unit, writes_dst: in_writes_dst};

    stage_reg #(.payload_t(issue_instr_t)) decode_latch (
        .clock(clock), .reset(reset),
        .load(load_dec), .bubble(1'b0),         // emptied by loading in_valid low
        .in_valid(in_valid), .in_data(in_instr),
        .valid(dec_valid), .data(dec_instr)
    );

    scoreboard scoreboard0 (
        .clock(clock), .reset(reset),
        .rd_a(rd_a), .rd_b(rd_b),
        .we(sb_we), .waddr(sb_waddr), .wunit(sb_wunit)
    );

    operand_bypass bypass_a (.rd(rd_a), .ready(ready_a), .fwd(fwd_a));
    operand_bypass bypass_b (.rd(rd_b), .ready(ready_b), .fwd(fwd_b));

    issue_control issue_control0 (
        .clock(clock), .reset(reset),
        .dec_valid(dec_valid), .dec_instr(dec_instr),
        .rd_a(rd_a), .rd_b(rd_b),
        .ready_a(ready_a), .ready_b(ready_b), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .in_valid(in_valid), .in_ready(in_ready), .load_dec(load_dec),
        .exec_load(exec_load), .exec_bubble(exec_bubble), .exec_op(exec_op),
        .sb_we(sb_we), .sb_waddr(sb_waddr), .sb_wunit(sb_wunit)
    );

    stage_reg #(.payload_t(exec_op_t)) exec_latch (
        .clock(clock), .reset(reset),
        .load(exec_load), .bubble(exec_bubble),
        .in_valid(dec_valid), .in_data(exec_op),
        .valid(out_valid), .data(exec_q)
    );

    // execute sees the exec latch directly
    assign out_src_a      = exec_q.instr.src_a;
    assign out_src_b      = exec_q.instr.src_b;
    assign out_dst        = exec_q.instr.dst;
    assign out_unit       = exec_q.instr.unit;
    assign out_writes_dst = exec_q.instr.writes_dst;
    assign out_fwd_a      = exec_q.fwd_a;
    assign out_fwd_b      = exec_q.fwd_b;

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;      // period 10
    end

    // reset low over the first 4 rising edges
    initial begin
        reset = 1'b0;
        repeat (4) @(posedge clock);
        #1 reset = 1'b1;                // off the edge, clear of the flops
    end

endmodule

// File: sim/issue_stage_tb.sv
module issue_stage_tb import issue_pkg::*; ();

    localparam int max_cases = 64;

    logic      clock;
    logic      reset;
    logic      in_valid;
    reg_addr_t in_src_a;
    reg_addr_t in_src_b;
    reg_addr_t in_dst;
    unit_t     in_unit;
    logic      in_writes_dst;
    logic      in_ready;
    logic      out_valid;
    reg_addr_t out_src_a;
    reg_addr_t out_src_b;
    reg_addr_t out_dst;
    unit_t     out_unit;
    logic      out_writes_dst;
    fwd_sel_t  out_fwd_a;
    fwd_sel_t  out_fwd_b;

    // columns as in the case file: src_a src_b dst unit writes_dst fwd_a fwd_b stalls
    int              tab [max_cases][8];
    logic [8*24-1:0] case_name [max_cases];
    int              n_cases;
    int              limit;
    int              exp_q [$];     // accepted ops, oldest first
    int              checked = 0;
    int              gap = 0;       // out_valid low cycles since last op
    int              cycles = 0;
    int              idx;

    tb_clock_gen clock_gen0 (.clock(clock), .reset(reset));

    issue_stage_top dut0 (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_src_a(in_src_a), .in_src_b(in_src_b),
        .in_dst(in_dst), .in_unit(in_unit), .in_writes_dst(in_writes_dst),
        .in_ready(in_ready),
        .out_valid(out_valid), .out_src_a(out_src_a), .out_src_b(out_src_b),
        .out_dst(out_dst), .out_unit(out_unit), .out_writes_dst(out_writes_dst),
        .out_fwd_a(out_fwd_a), .out_fwd_b(out_fwd_b)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_field(input logic [8*24-1:0] name, input string field,
                               input int expected, input int actual);
        if (expected != actual) begin
            abort_run($sformatf("FAILED %0s %s expected %0d actual %0d",
                                name, field, expected, actual));
        end
    endtask

    task automatic read_cases();
        int              fd;
        string           line;
        logic [8*24-1:0] name;
        fd = $fopen("sim/issue_cases.txt", "r");
        if (fd == 0) abort_run("could not open sim/issue_cases.txt");
        n_cases = 0;
        while (!$feof(fd) && n_cases < max_cases) begin
            // comment and blank lines do not give 9 fields
            if ($fgets(line, fd) > 0 &&
                $sscanf(line, "%s %d %d %d %d %d %d %d %d", name,
                        tab[n_cases][0], tab[n_cases][1], tab[n_cases][2],
                        tab[n_cases][3], tab[n_cases][4], tab[n_cases][5],
                        tab[n_cases][6], tab[n_cases][7]) == 9) begin
                case_name[n_cases] = name;
                n_cases++;
            end
        end
        $fclose(fd);
        if (n_cases == 0) abort_run("no cases found in sim/issue_cases.txt");
    endtask

    // present one op and hold it until taken
    task automatic send_case(input int i);
        in_valid      = 1'b1;
        in_src_a      = 5'(tab[i][0]);
        in_src_b      = 5'(tab[i][1]);
        in_dst        = 5'(tab[i][2]);
        in_unit       = 2'(tab[i][3]);
        in_writes_dst = 1'(tab[i][4]);
        @(negedge clock);
        while (!in_ready) @(negedge clock);
        @(posedge clock);           // accepted here
        exp_q.push_back(i);
        #1;
    endtask

    // cycle budget against a hung DUT
    always @(posedge clock) begin
        cycles++;
        if (cycles > limit) abort_run($sformatf("run hung, not done after %0d cycles", limit));
    end

    // outputs are flop driven, settled by the falling edge
    always @(negedge clock) begin
        if (out_valid) begin
            if (exp_q.size() == 0) abort_run("out_valid high with no op outstanding");
            idx = exp_q.pop_front();
            check_field(case_name[idx], "src_a", tab[idx][0], 32'(out_src_a));
            check_field(case_name[idx], "src_b", tab[idx][1], 32'(out_src_b));
            check_field(case_name[idx], "dst", tab[idx][2], 32'(out_dst));
            check_field(case_name[idx], "unit", tab[idx][3], 32'(out_unit));
            check_field(case_name[idx], "writes_dst", tab[idx][4], 32'(out_writes_dst));
            check_field(case_name[idx], "fwd_a", tab[idx][5], 32'(out_fwd_a));
            check_field(case_name[idx], "fwd_b", tab[idx][6], 32'(out_fwd_b));
            if (checked > 0) check_field(case_name[idx], "stalls", tab[idx][7], gap);
            gap = 0;
            checked++;
        end else begin
            gap++;          // bubble, or reset before the first op
        end
    end

    initial begin
        in_valid      = 1'b0;
        in_src_a      = '0;
        in_src_b      = '0;
        in_dst        = '0;
        in_unit       = '0;
        in_writes_dst = 1'b0;
        read_cases();
        limit = n_cases * 6 + 20;
        @(posedge reset);
        @(posedge clock);
        #1;
        check_field("after_reset", "in_ready", 1, 32'(in_ready));   // decode latch empty
        for (int i = 0; i < n_cases; i++) send_case(i);
        in_valid = 1'b0;
        wait (checked == n_cases);
        $display("Test OK");
        $finish;
    end

endmodule

// File: sim/issue_cases.txt
# columns: name src_a src_b dst unit writes_dst fwd_a fwd_b stalls
# unit 0 alu 1 mem 2 mult 3 mult, fwd 0 none 1 alu 2 mem 3 mult
ind_a       1  2 10 0 1 0 0 0
ind_b       3  4 11 0 1 0 0 0
ind_c       5  6 12 0 1 0 0 0
alu_prod    1  2 13 0 1 0 0 0
alu_dep    13  2 14 0 1 1 0 1
mem_prod    1  2 15 1 1 0 0 0
mem_dep     1 15 16 0 1 0 2 2
mult_prod   1  2 17 2 1 0 0 0
mult_dep   17 17 18 0 1 3 3 4
two_mem     1  2 19 1 1 0 0 0
two_alu     1  2 20 0 1 0 0 0
two_dep    20 19 21 0 1 1 2 1
r0_mult     1  2  0 2 1 0 0 0
r0_read     0  0 22 0 1 0 0 0
nowr_mult   1  2 23 2 0 0 0 0
nowr_read  23  1 24 0 1 0 0 0
waw_mult    1  2 25 2 1 0 0 0
waw_alu     1  2 25 0 1 0 0 4
waw_read   25  1 26 0 1 1 0 1
code3_prod  1  2 27 3 1 0 0 0
code3_dep   1 27 28 0 1 0 3 4
tail        3  4 29 1 1 0 0 0

// File: list.f
common/issue_pkg.sv
common/sb_read_if.sv
scoreboard/scoreboard.sv
verilog/stage_reg.sv
verilog/operand_bypass.sv
verilog/issue_control.sv
verilog/issue_stage_top.sv
sim/tb_clock_gen.sv
sim/issue_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the issue stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module issue_stage_tb \
    -Mdir obj_dir -o issue_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/issue_stage_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
